// ==== dv/fpuConvChecker.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpuConvChecker
	import fpuApbPkg::*;
(
	input  logic                    clock,
	input  logic                    rst,
	input  apbReq                   apbIn,
	input  apbRsp                   apbOut,
	input  logic                    expCheck,
	input  logic [apbDataWidth-1:0] expData,
	input  logic                    expErr,
	output int                      errorCount
);

	logic access;

	assign access = apbIn.psel && apbIn.penable;

	// Every access completes in its access cycle. Armed accesses are compared in full.
	always @(posedge clock)
	begin
		if (rst)
			errorCount = 0;
		else if (access)
		begin
			if (apbOut.pready !== 1'b1)
			begin
				$display("FAILED at %0t ns: pready low at offset 0x%02h",
					$time, apbIn.paddr);
				errorCount = errorCount + 1;
			end
			if (expCheck && (apbOut.pslverr !== expErr))
			begin
				$display("FAILED at %0t ns: pslverr %0b at offset 0x%02h, expected %0b",
					$time, apbOut.pslverr, apbIn.paddr, expErr);
				errorCount = errorCount + 1;
			end
			if (expCheck && !expErr && !apbIn.pwrite && (apbOut.prdata !== expData))
			begin
				$display("FAILED at %0t ns: read of 0x%02h gave 0x%08h, expected 0x%08h",
					$time, apbIn.paddr, apbOut.prdata, expData);
				errorCount = errorCount + 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/fpuConvTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpuConvTb
	import fpuApbPkg::*;
	import fpuConvPkg::*;
();

	logic        clock;
	logic        rst;
	apbReq       apbIn;
	apbRsp       apbOut;
	logic        expCheck;
	logic [31:0] expData;
	logic        expErr;
	int          chkErrors;
	int          timeoutCount;
	logic        stickyInvalid; // Model of the sticky status flags.
	logic        stickyInexact;
	logic [31:0] rdData;
	convRsp      d2iWant;
	convRsp      i2dWant;

	fpuConvUnit dut0 (
		.clock  (clock),
		.rst    (rst),
		.apbIn  (apbIn),
		.apbOut (apbOut)
	);

	fpuConvChecker chk0 (
		.clock      (clock),
		.rst        (rst),
		.apbIn      (apbIn),
		.apbOut     (apbOut),
		.expCheck   (expCheck),
		.expData    (expData),
		.expErr     (expErr),
		.errorCount (chkErrors)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// ########################################################################
	// Reference models built from the field rules.
	function automatic convRsp refD2I(input logic [63:0] value);
		convRsp      r;
		logic [10:0] e;
		logic [63:0] mant;
		logic [63:0] mag;
		logic [63:0] lost;
		int          shift;
		r = '0;
		e = value[62:52];
		mant = {11'd0, 1'b1, value[51:0]};
		shift = int'(e) - 1023;
		if ((e == expAllOnes) && (value[51:0] != '0))
		begin
			r.result = intMin;
			r.invalid = 1'b1;
		end
		else if (e < expBias)
			r.inexact = (value[62:0] != '0);
		else if ((e > expMaxInt) || ((shift == 63) && !(value[63] && (value[51:0] == '0))))
		begin
			r.result = value[63] ? intMin : intMax;
			r.invalid = 1'b1;
		end
		else
		begin
			if (shift >= 52)
				mag = mant << (shift - 52);
			else
			begin
				mag = mant >> (52 - shift);
				lost = mant << (12 + shift); // Only the dropped bits survive.
				r.inexact = (lost != '0);
			end
			r.result = value[63] ? -mag : mag;
		end
		return r;
	endfunction

	function automatic convRsp refI2D(input logic [63:0] value);
		convRsp      r;
		logic [63:0] mag;
		logic [63:0] kept;
		logic [63:0] rem;
		logic [63:0] half;
		logic [10:0] e;
		int          msb;
		int          drop;
		r = '0;
		mag = value[63] ? -value : value;
		msb = 0;
		for (int i = 0; i < 64; i++)
		begin
			if (mag[i])
				msb = i;
		end
		e = 11'(1023 + msb);
		if (msb <= 52)
			kept = mag << (52 - msb);
		else
		begin
			drop = msb - 52;
			kept = mag >> drop;
			rem = mag & ((64'd1 << drop) - 64'd1);
			half = 64'd1 << (drop - 1);
			r.inexact = (rem != '0);
			if ((rem > half) || ((rem == half) && kept[0]))
				kept = kept + 64'd1;
			if (kept[53])
			begin
				kept = kept >> 1;
				e = e + 11'd1;
			end
		end
		if (value != '0)
			r.result = {value[63], e, kept[51:0]};
		return r;
	endfunction

	function automatic logic [31:0] expStatus(input logic doneBit);
		return {29'd0, stickyInexact, stickyInvalid, doneBit};
	endfunction

	function automatic logic [63:0] randInRange();
		logic [10:0] e;
		e = expBias + 11'($urandom % 64);
		return {1'($urandom), e, 52'({$urandom, $urandom})};
	endfunction

	function automatic logic [63:0] randInt();
		logic [63:0] value;
		value = {$urandom, $urandom} >> ($urandom % 64); // Spread the magnitudes.
		return ($urandom % 2) ? -value : value;
	endfunction

	// ########################################################################
	// APB driver tasks.
	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, input logic errExp);
		@(negedge clock);
		apbIn.psel = 1'b1;
		apbIn.penable = 1'b0;
		apbIn.pwrite = 1'b1;
		apbIn.paddr = addr;
		apbIn.pwdata = data;
		expCheck = 1'b1;
		expData = '0;
		expErr = errExp;
		@(negedge clock);
		apbIn.penable = 1'b1;
		@(negedge clock);
		apbIn.psel = 1'b0;
		apbIn.penable = 1'b0;
		expCheck = 1'b0;
	endtask

	task automatic apbRead(input logic [7:0] addr, input logic check, input logic [31:0] want,
		input logic errExp, output logic [31:0] data);
		@(negedge clock);
		apbIn.psel = 1'b1;
		apbIn.penable = 1'b0;
		apbIn.pwrite = 1'b0;
		apbIn.paddr = addr;
		apbIn.pwdata = '0;
		expCheck = check;
		expData = want;
		expErr = errExp;
		@(negedge clock);
		apbIn.penable = 1'b1;
		@(posedge clock);
		data = apbOut.prdata;
		@(negedge clock);
		apbIn.psel = 1'b0;
		apbIn.penable = 1'b0;
		expCheck = 1'b0;
	endtask

	task automatic writeOperand(input logic [63:0] value);
		apbWrite(regOpLo, value[31:0], 1'b0);
		apbWrite(regOpHi, value[63:32], 1'b0);
	endtask

	task automatic waitDone();
		logic [31:0] status;
		int          tries;
		status = '0;
		tries = 0;
		while (!status[statDone] && (tries < 20))
		begin
			apbRead(regStatus, 1'b0, '0, 1'b0, status);
			tries++;
		end
		if (!status[statDone])
		begin
			$display("Timeout: done did not rise within %0d status polls at %0t ns", tries, $time);
			timeoutCount++;
		end
	endtask

	task automatic checkResult(input convRsp want);
		apbRead(regResLo, 1'b1, want.result[31:0], 1'b0, rdData);
		apbRead(regResHi, 1'b1, want.result[63:32], 1'b0, rdData);
		apbRead(regStatus, 1'b1, expStatus(1'b1), 1'b0, rdData);
	endtask

	task automatic convert(input convOp op, input logic [63:0] value);
		convRsp want;
		if (op == opD2I)
			want = refD2I(value);
		else
			want = refI2D(value);
		writeOperand(value);
		apbWrite(regCtrl, {31'd0, op}, 1'b0);
		apbRead(regStatus, 1'b1, expStatus(1'b0), 1'b0, rdData); // Issue has cleared done.
		waitDone();
		stickyInvalid = stickyInvalid | want.invalid;
		stickyInexact = stickyInexact | want.inexact;
		checkResult(want);
	endtask

	// ########################################################################
	// Stimulus.
	initial
	begin
		void'($urandom(32'h2efa));
		rst = 1'b1;
		apbIn = '0;
		expCheck = 1'b0;
		expData = '0;
		expErr = 1'b0;
		timeoutCount = 0;
		stickyInvalid = 1'b0;
		stickyInexact = 1'b0;
		rdData = '0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;

		apbRead(regStatus, 1'b1, 32'h0, 1'b0, rdData);
		writeOperand(64'h9ABC_DEF0_1234_5678);
		apbRead(regOpLo, 1'b1, 32'h1234_5678, 1'b0, rdData);
		apbRead(regOpHi, 1'b1, 32'h9ABC_DEF0, 1'b0, rdData);
		apbRead(8'h18, 1'b1, 32'h0, 1'b1, rdData);
		apbWrite(8'h3C, 32'h1, 1'b1);
		apbWrite(regResLo, 32'h0, 1'b1); // Result registers are read-only.

		repeat (40) convert(opD2I, randInRange());

		convert(opD2I, 64'h0000_0000_0000_0000);
		convert(opD2I, 64'h8000_0000_0000_0000);
		convert(opD2I, 64'h3FE0_0000_0000_0000);
		convert(opD2I, 64'hBFEF_FFFF_FFFF_FFFF);
		convert(opD2I, 64'h0000_0000_0000_0001);
		convert(opD2I, 64'h3FF0_0000_0000_0000);
		convert(opD2I, 64'h433F_FFFF_FFFF_FFFF);
		convert(opD2I, 64'h43F0_0000_0000_0000);
		convert(opD2I, 64'hC3F0_0000_0000_0000);
		convert(opD2I, 64'h43E0_0000_0000_0000);
		convert(opD2I, 64'hC3E0_0000_0000_0000); // Exactly -2^63.
		convert(opD2I, 64'hC3E0_0000_0000_0001);
		convert(opD2I, 64'h7FF8_0000_0000_0000);
		convert(opD2I, 64'hFFF0_0000_0000_0001);
		convert(opD2I, 64'h7FF0_0000_0000_0000);
		convert(opD2I, 64'hFFF0_0000_0000_0000);

		// Both flags are set now and must survive a clean conversion.
		convert(opI2D, 64'd1);
		apbRead(regCtrl, 1'b1, 32'h1, 1'b0, rdData);
		apbWrite(regStatus, 32'h6, 1'b0);
		stickyInvalid = 1'b0;
		stickyInexact = 1'b0;
		apbRead(regStatus, 1'b1, expStatus(1'b1), 1'b0, rdData);

		convert(opI2D, 64'd0);
		convert(opI2D, 64'hFFFF_FFFF_FFFF_FFFF);
		convert(opI2D, intMax);
		convert(opI2D, intMin);
		repeat (40) convert(opI2D, randInt());

		// ####################################################################
		// Back-to-back issue on a NaN pattern that is inexact as an integer.
		apbWrite(regStatus, 32'h6, 1'b0);
		writeOperand(64'h7FF8_0000_0000_0001);
		d2iWant = refD2I(64'h7FF8_0000_0000_0001);
		i2dWant = refI2D(64'h7FF8_0000_0000_0001);
		apbWrite(regCtrl, {31'd0, opD2I}, 1'b0);
		apbWrite(regCtrl, {31'd0, opI2D}, 1'b0);
		waitDone();
		stickyInvalid = d2iWant.invalid | i2dWant.invalid;
		stickyInexact = d2iWant.inexact | i2dWant.inexact;
		checkResult(i2dWant);

		$display("Closing summary: %0d compare errors, %0d timeouts", chkErrors, timeoutCount);
		if ((chkErrors == 0) && (timeoutCount == 0))
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fpuConvUnit.f ====
src/fpuApbPkg.sv
src/fpuConvPkg.sv
src/fpuConvD2I.sv
src/fpuConvI2D.sv
src/fpuConvRegs.sv
src/fpuConvUnit.sv
dv/fpuConvChecker.sv
dv/fpuConvTb.sv

// ==== src/fpuApbPkg.sv ====
`default_nettype none

package fpuApbPkg;

	localparam int apbAddrWidth = 8;
	localparam int apbDataWidth = 32;

	// Requester side of the bus.
	typedef struct packed {
		logic                    psel;
		logic                    penable;
		logic                    pwrite;
		logic [apbAddrWidth-1:0] paddr;
		logic [apbDataWidth-1:0] pwdata;
	} apbReq;

	// Completer side of the bus.
	typedef struct packed {
		logic [apbDataWidth-1:0] prdata;
		logic                    pready;
		logic                    pslverr;
	} apbRsp;

endpackage

`default_nettype wire

// ==== src/fpuConvD2I.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpuConvD2I
	import fpuConvPkg::*;
(
	input  logic                clock,
	input  logic                rst,
	input  logic                inValid,
	input  logic [intWidth-1:0] operand,
	output logic                outValid,
	output convRsp              rsp
);

	logic [expWidth-1:0]   opExp;
	logic [fracWidth-1:0]  opFrac;

	logic                  s1Valid;
	logic                  s1Sign;
	logic [expWidth-1:0]   s1Exp;
	logic [fracWidth-1:0]  s1Frac;
	logic                  s1Small;
	logic                  s1Ovf;
	logic                  s1Nan;

	logic [expWidth-1:0]   expDiff;
	logic [2*intWidth-1:0] shifted;

	logic                  s2Valid;
	logic                  s2Sign;
	logic [intWidth-1:0]   s2Mag;
	logic                  s2Inexact;
	logic                  s2Small;
	logic                  s2Ovf;
	logic                  s2Nan;

	logic                  magOvf;

	assign opExp  = operand[intWidth-2 -: expWidth];
	assign opFrac = operand[fracWidth-1:0];

	// ########################################################################
	// Stage 1 splits the fields and classifies the operand.
	always_ff @(posedge clock)
	begin
		if (rst)
			s1Valid <= 1'b0;
		else
			s1Valid <= inValid;
		s1Sign  <= operand[intWidth-1];
		s1Exp   <= opExp;
		s1Frac  <= opFrac;
		s1Small <= opExp < expBias; // Magnitude below 1.0 truncates to zero.
		s1Ovf   <= opExp > expMaxInt;
		s1Nan   <= (opExp == expAllOnes) && (opFrac != '0);
	end

	// Only the low six bits matter once the operand is known to be in range.
	assign expDiff = s1Exp - expBias;
	assign shifted = {{(2*intWidth-fracWidth-1){1'b0}}, 1'b1, s1Frac} << expDiff[5:0];

	// ########################################################################
	// Stage 2 aligns the mantissa. The binary point sits below bit fracWidth.
	always_ff @(posedge clock)
	begin
		if (rst)
			s2Valid <= 1'b0;
		else
			s2Valid <= s1Valid;
		s2Sign  <= s1Sign;
		s2Mag   <= shifted[fracWidth +: intWidth];
		s2Small <= s1Small;
		s2Ovf   <= s1Ovf;
		s2Nan   <= s1Nan;
		if (s1Small)
			s2Inexact <= (s1Exp != '0) || (s1Frac != '0);
		else
			s2Inexact <= !s1Ovf && (shifted[fracWidth-1:0] != '0);
	end

	// Anything at 2^63 or above overflows except an exact -2^63.
	// A small operand has a wrapped shift, so its magnitude means nothing.
	assign magOvf = !s2Small && s2Mag[intWidth-1]
		&& !(s2Sign && (s2Mag[intWidth-2:0] == '0));

	// ########################################################################
	// Stage 3 applies the sign and the saturation rules.
	always_ff @(posedge clock)
	begin
		if (rst)
			outValid <= 1'b0;
		else
			outValid <= s2Valid;
		if (s2Nan)
		begin
			rsp.result  <= intMin;
			rsp.invalid <= 1'b1;
			rsp.inexact <= 1'b0;
		end
		else if (s2Ovf || magOvf)
		begin
			rsp.result  <= s2Sign ? intMin : intMax;
			rsp.invalid <= 1'b1;
			rsp.inexact <= 1'b0;
		end
		else
		begin
			rsp.result  <= s2Small ? '0 : (s2Sign ? -s2Mag : s2Mag);
			rsp.invalid <= 1'b0;
			rsp.inexact <= s2Inexact;
		end
	end

endmodule

`default_nettype wire

// ==== src/fpuConvI2D.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpuConvI2D
	import fpuConvPkg::*;
(
	input  logic                clock,
	input  logic                rst,
	input  logic                inValid,
	input  logic [intWidth-1:0] operand,
	output logic                outValid,
	output convRsp              rsp
);

	logic                   s1Valid;
	logic                   s1Sign;
	logic [intWidth-1:0]    s1Mag;

	logic [6:0]             leadZeros;
	logic [expWidth-1:0]    normExp;

	logic                   s2Valid;
	logic                   s2Sign;
	logic [intWidth-1:0]    s2Norm;
	logic [expWidth-1:0]    s2Exp;
	logic                   s2Zero;

	logic [fracWidth:0]     kept;
	logic                   guardBit;
	logic                   stickyBit;
	logic                   roundUp;
	logic [fracWidth+1:0]   rounded;

	// Returns 64 for a zero input.
	function automatic logic [6:0] countLz(input logic [intWidth-1:0] value);
		logic [6:0] count;
		count = 7'd64;
		for (int i = 0; i < intWidth; i++)
		begin
			if (value[i])
				count = 7'(intWidth - 1 - i); // The highest set bit is seen last.
		end
		return count;
	endfunction

	// ########################################################################
	// Stage 1 takes the absolute value. intMin becomes 2^63 unsigned.
	always_ff @(posedge clock)
	begin
		if (rst)
			s1Valid <= 1'b0;
		else
			s1Valid <= inValid;
		s1Sign <= operand[intWidth-1];
		s1Mag  <= operand[intWidth-1] ? -operand : operand;
	end

	assign leadZeros = countLz(s1Mag);
	assign normExp   = expBias + 11'd63 - {4'd0, leadZeros};

	// Stage 2 normalizes so that the leading one lands in the top bit.
	always_ff @(posedge clock)
	begin
		if (rst)
			s2Valid <= 1'b0;
		else
			s2Valid <= s1Valid;
		s2Sign <= s1Sign;
		s2Norm <= s1Mag << leadZeros[5:0];
		s2Exp  <= normExp;
		s2Zero <= leadZeros[6];
	end

	// ########################################################################
	// Stage 3 rounds to nearest even on the 53 kept bits.
	assign kept      = s2Norm[intWidth-1 -: fracWidth+1];
	assign guardBit  = s2Norm[intWidth-fracWidth-2];
	assign stickyBit = |s2Norm[intWidth-fracWidth-3:0];
	assign roundUp   = guardBit && (stickyBit || kept[0]);
	assign rounded   = {1'b0, kept} + {{(fracWidth+1){1'b0}}, roundUp};

	always_ff @(posedge clock)
	begin
		if (rst)
			outValid <= 1'b0;
		else
			outValid <= s2Valid;
		if (s2Zero)
			rsp.result <= '0; // Positive zero.
		else if (rounded[fracWidth+1])
			rsp.result <= {s2Sign, s2Exp + 1'b1, rounded[fracWidth:1]};
		else
			rsp.result <= {s2Sign, s2Exp, rounded[fracWidth-1:0]};
		rsp.invalid <= 1'b0;
		rsp.inexact <= guardBit || stickyBit;
	end

endmodule

`default_nettype wire

// ==== src/fpuConvPkg.sv ====
`default_nettype none

package fpuConvPkg;

	// ########################################################################
	// Double format and integer limits.
	localparam int intWidth  = 64;
	localparam int fracWidth = 52;
	localparam int expWidth  = 11;

	localparam logic [expWidth-1:0] expBias    = 11'h3FF;
	localparam logic [expWidth-1:0] expMaxInt  = 11'h43E; // 2^63 still fits when negative.
	localparam logic [expWidth-1:0] expAllOnes = 11'h7FF;

	localparam logic [intWidth-1:0] intMin = 64'h8000_0000_0000_0000;
	localparam logic [intWidth-1:0] intMax = 64'h7FFF_FFFF_FFFF_FFFF;

	// ########################################################################
	// Register map of the conversion unit.
	localparam logic [7:0] regCtrl   = 8'h00;
	localparam logic [7:0] regOpLo   = 8'h04;
	localparam logic [7:0] regOpHi   = 8'h08;
	localparam logic [7:0] regResLo  = 8'h0C;
	localparam logic [7:0] regResHi  = 8'h10;
	localparam logic [7:0] regStatus = 8'h14;

	localparam int statDone    = 0;
	localparam int statInvalid = 1;
	localparam int statInexact = 2;

	// CTRL bit 0 selects the converter.
	typedef enum logic {
		opD2I = 1'b0,
		opI2D = 1'b1
	} convOp;

	typedef struct packed {
		logic [intWidth-1:0] result;
		logic                invalid;
		logic                inexact;
	} convRsp;

endpackage

`default_nettype wire

// ==== src/fpuConvRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpuConvRegs
	import fpuApbPkg::*;
	import fpuConvPkg::*;
(
	input  logic                clock,
	input  logic                rst,
	input  apbReq               apbIn,
	output apbRsp               apbOut,
	output logic                d2iValid,
	output logic                i2dValid,
	output logic [intWidth-1:0] operand,
	input  logic                d2iOutValid,
	input  convRsp              d2iRsp,
	input  logic                i2dOutValid,
	input  convRsp              i2dRsp
);

	logic                    access;
	logic                    wrAccess;
	logic                    addrOk;
	logic                    readOnly;
	logic                    wrCtrl;
	logic                    wrOpLo;
	logic                    wrOpHi;
	logic                    wrStatus;
	convOp                   issueOp;

	logic [apbDataWidth-1:0] opLo;
	logic [apbDataWidth-1:0] opHi;
	logic [intWidth-1:0]     result;
	convOp                   lastOp;
	logic                    done;
	logic                    flagInvalid;
	logic                    flagInexact;
	logic [1:0]              pendCnt; // Conversions still in flight.

	logic                    complete;
	convRsp                  doneRsp;
	logic [apbDataWidth-1:0] statusWord;
	logic [apbDataWidth-1:0] readData;

	// ########################################################################
	// APB decode.
	assign access   = apbIn.psel && apbIn.penable;
	assign wrAccess = access && apbIn.pwrite;
	assign wrCtrl   = wrAccess && (apbIn.paddr == regCtrl);
	assign wrOpLo   = wrAccess && (apbIn.paddr == regOpLo);
	assign wrOpHi   = wrAccess && (apbIn.paddr == regOpHi);
	assign wrStatus = wrAccess && (apbIn.paddr == regStatus);
	assign issueOp  = convOp'(apbIn.pwdata[0]);

	always_comb
	begin
		addrOk   = 1'b1;
		readOnly = 1'b0;
		case (apbIn.paddr)
			regCtrl, regOpLo, regOpHi, regStatus: readOnly = 1'b0;
			regResLo, regResHi:                   readOnly = 1'b1;
			default:                              addrOk   = 1'b0;
		endcase
	end

	always_comb
	begin
		statusWord              = '0;
		statusWord[statDone]    = done;
		statusWord[statInvalid] = flagInvalid;
		statusWord[statInexact] = flagInexact;
	end

	always_comb
	begin
		case (apbIn.paddr)
			regCtrl:   readData = {{(apbDataWidth-1){1'b0}}, lastOp};
			regOpLo:   readData = opLo;
			regOpHi:   readData = opHi;
			regResLo:  readData = result[apbDataWidth-1:0];
			regResHi:  readData = result[intWidth-1:apbDataWidth];
			regStatus: readData = statusWord;
			default:   readData = '0;
		endcase
	end

	assign apbOut.prdata  = readData;
	assign apbOut.pready  = 1'b1; // No wait states.
	assign apbOut.pslverr = access && (!addrOk || (apbIn.pwrite && readOnly));

	assign operand = {opHi, opLo};

	// Both converters share one latency, so their results never collide.
	assign complete = d2iOutValid || i2dOutValid;
	assign doneRsp  = d2iOutValid ? d2iRsp : i2dRsp;

	// ########################################################################
	// Register state.
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			opLo        <= '0;
			opHi        <= '0;
			result      <= '0;
			lastOp      <= opD2I;
			d2iValid    <= 1'b0;
			i2dValid    <= 1'b0;
			done        <= 1'b0;
			flagInvalid <= 1'b0;
			flagInexact <= 1'b0;
			pendCnt     <= '0;
		end
		else
		begin
			d2iValid <= wrCtrl && (issueOp == opD2I);
			i2dValid <= wrCtrl && (issueOp == opI2D);
			if (wrOpLo)
				opLo <= apbIn.pwdata;
			if (wrOpHi)
				opHi <= apbIn.pwdata;
			if (wrCtrl)
				lastOp <= issueOp;
			if (complete)
				result <= doneRsp.result;

			if (wrCtrl && !complete)
				pendCnt <= pendCnt + 2'd1;
			else if (!wrCtrl && complete)
				pendCnt <= pendCnt - 2'd1;

			// Done waits for the last conversion in flight.
			if (wrCtrl)
				done <= 1'b0;
			else if (complete && (pendCnt == 2'd1))
				done <= 1'b1;

			flagInvalid <= (flagInvalid && !(wrStatus && apbIn.pwdata[statInvalid]))
				|| (complete && doneRsp.invalid);
			flagInexact <= (flagInexact && !(wrStatus && apbIn.pwdata[statInexact]))
				|| (complete && doneRsp.inexact);
		end
	end

endmodule

`default_nettype wire

// ==== src/fpuConvUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpuConvUnit
	import fpuApbPkg::*;
	import fpuConvPkg::*;
(
	input  logic  clock,
	input  logic  rst,
	input  apbReq apbIn,
	output apbRsp apbOut
);

	logic                d2iValid;
	logic                i2dValid;
	logic [intWidth-1:0] operand; // Shared by both converters.
	logic                d2iOutValid;
	logic                i2dOutValid;
	convRsp              d2iRsp;
	convRsp              i2dRsp;

	fpuConvRegs regs0 (
		.clock       (clock),
		.rst         (rst),
		.apbIn       (apbIn),
		.apbOut      (apbOut),
		.d2iValid    (d2iValid),
		.i2dValid    (i2dValid),
		.operand     (operand),
		.d2iOutValid (d2iOutValid),
		.d2iRsp      (d2iRsp),
		.i2dOutValid (i2dOutValid),
		.i2dRsp      (i2dRsp)
	);

	fpuConvD2I d2i0 (
		.clock    (clock),
		.rst      (rst),
		.inValid  (d2iValid),
		.operand  (operand),
		.outValid (d2iOutValid),
		.rsp      (d2iRsp)
	);

	fpuConvI2D i2d0 (
		.clock    (clock),
		.rst      (rst),
		.inValid  (i2dValid),
		.operand  (operand),
		.outValid (i2dOutValid),
		.rsp      (i2dRsp)
	);

endmodule

`default_nettype wire
